//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_bch_syndrome -f filelist.f -o tb_sim
	out=$$(./obj_dir/tb_sim); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- bch_beat_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "bch_defines.svh"

// one accepted beat as seen by the syndrome units
interface bch_beat_if;

	logic ce; // beat accepted this cycle
	logic start; // beat is the first of a frame
	logic last; // beat is the final one of a frame
	logic [`BCH_BITS-1:0] data; // bit BCH_BITS-1 is the highest coefficient

	// ~~~~~~~~~~~~~~~~~~~~
	// modports
	// ~~~~~~~~~~~~~~~~~~~~

	modport ctrl (
		output ce,
		output start,
		output last,
		output data
	);

	modport unit (
		input ce,
		input start,
		input last,
		input data
	);

endinterface

`default_nettype wire

//--- bch_defines.svh
`ifndef BCH_DEFINES_SVH
`define BCH_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~
// field parameters
// ~~~~~~~~~~~~~~~~~~~~

`define BCH_M 4 // bits per GF(2^4) element
`define BCH_POLY 5'b10011 // x^4 + x + 1, primitive so alpha has order 15

// ~~~~~~~~~~~~~~~~~~~~
// code parameters
// ~~~~~~~~~~~~~~~~~~~~

`define BCH_N 15 // codeword length, also the multiplicative order of alpha
`define BCH_K 7 // message length of the (15,7) code
`define BCH_T 2 // correctable errors, so 2*t syndromes in all

// ~~~~~~~~~~~~~~~~~~~~
// beat framing
// ~~~~~~~~~~~~~~~~~~~~

// a codeword is cut into beats, highest coefficients first
`define BCH_BITS 3 // coefficients per beat
`define BCH_BEATS 5 // beats per codeword, BCH_BITS * BCH_BEATS == BCH_N

`endif

//--- bch_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "bch_defines.svh"

// turns the raw beat strobes into frame-qualified beats
//
// in_first with in_valid always opens a frame, even in the middle of one
// a beat without in_first while idle is dropped
module bch_frame_ctrl import bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic in_first,
	input logic [`BCH_BITS-1:0] in_data,
	bch_beat_if.ctrl beat,
	output logic last
);

	localparam int cnt_w = $clog2(`BCH_BEATS); // enough for beat indices 0..BEATS-1

	frame_state_t state;
	logic [cnt_w-1:0] cnt; // beats already taken in the current frame
	logic [cnt_w-1:0] beat_idx; // index of the beat on the inputs now
	logic accept;
	logic first;
	logic frame_last;

	// ~~~~~~~~~~~~~~~~~~~~
	// beat qualification
	// ~~~~~~~~~~~~~~~~~~~~

	assign first = in_valid & in_first;
	assign accept = first | (in_valid & (state == FRAME_RUN));

	// a restart counts from zero no matter where the old frame was
	assign beat_idx = first ? '0 : cnt;
	assign frame_last = accept & (beat_idx == cnt_w'(`BCH_BEATS - 1));

	assign beat.ce = accept;
	assign beat.start = first;
	assign beat.last = frame_last;
	assign beat.data = in_data; // passes straight on, ce says if it counts

	assign last = frame_last; // the check stage keys its capture on this

	// ~~~~~~~~~~~~~~~~~~~~
	// state and count
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FRAME_IDLE;
			cnt <= '0;
		end else if (accept) begin
			if (frame_last) begin
				// a first beat on the next cycle brings it straight back to run
				state <= FRAME_IDLE;
				cnt <= '0;
			end else begin
				state <= FRAME_RUN;
				cnt <= beat_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- bch_pkg.sv
`default_nettype none

`include "bch_defines.svh"

package bch_pkg;

	// one field element in standard basis, bit i is the alpha^i coefficient
	typedef logic [`BCH_M-1:0] gf_elem_t;

	// element j-1 holds S_j
	typedef gf_elem_t [2*`BCH_T-1:0] syn_vec_t;

	typedef enum logic {
		FRAME_IDLE, // waiting for a beat with in_first
		FRAME_RUN // inside a frame, counting beats
	} frame_state_t;

	// multiply by alpha once, shift and fold the overflow bit back in
	function automatic gf_elem_t gf_mul_x(input gf_elem_t v);
		logic [`BCH_M:0] poly;
		poly = `BCH_POLY;
		return {v[`BCH_M-2:0], 1'b0} ^ (v[`BCH_M-1] ? poly[`BCH_M-1:0] : '0);
	endfunction

	// alpha^e for elaboration-time constants, exponent wraps at the field order
	function automatic gf_elem_t gf_alpha_pow(input int unsigned e);
		gf_elem_t r;
		int unsigned k;
		r = gf_elem_t'(1);
		for (k = 0; k < e % `BCH_N; k++) begin
			r = gf_mul_x(r);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

//--- bch_syn_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "bch_defines.svh"

// builds the full syndrome set from S1 and S3 and flags a non-codeword
//
// for a binary code S_2j = S_j^2, so S2 and S4 need only two squarers
module bch_syn_check import bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic last,
	input gf_elem_t s1,
	input gf_elem_t s3,
	output syn_vec_t syn_out,
	output logic syn_valid,
	output logic err_detected
);

	logic last_d; // units hold finished syndromes while this is high
	gf_elem_t s2;
	gf_elem_t s4;
	syn_vec_t syn_full;

	gf_mult u_sq2 (
		.a(s1),
		.b(s1),
		.p(s2) // S2 = S1^2
	);

	gf_mult u_sq4 (
		.a(s2),
		.b(s2),
		.p(s4) // S4 = S2^2 = S1^4
	);

	assign syn_full = {s4, s3, s2, s1}; // S1 sits in element 0

	// ~~~~~~~~~~~~~~~~~~~~
	// capture
	// ~~~~~~~~~~~~~~~~~~~~

	// a beat of the next frame may already be in the units this cycle,
	// their outputs only change at the same edge that captures them
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_d <= 1'b0;
			syn_valid <= 1'b0;
			syn_out <= '0;
			err_detected <= 1'b0;
		end else begin
			last_d <= last;
			syn_valid <= last_d; // one pulse per finished frame
			if (last_d) begin
				syn_out <= syn_full;
				err_detected <= |syn_full; // any non-zero syndrome means an error
			end
		end
	end

endmodule

`default_nettype wire

//--- bch_syn_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bch_defines.svh"

// Horner accumulator for one odd syndrome S_j = r(alpha^j)
//
// each beat holds the next BCH_BITS coefficients, highest first, so one step is
// acc = acc * alpha^(bits*j) + sum data[i] * alpha^(i*j)
//
// after the final beat the accumulator holds r(alpha^j)
module bch_syn_unit import bch_pkg::*; #(
	parameter int unsigned syn_idx = 1 // any odd index, even ones come from squaring
) (
	input logic clk,
	input logic rst_n,
	bch_beat_if.unit beat,
	output gf_elem_t syn
);

	// ~~~~~~~~~~~~~~~~~~~~
	// fixed coefficients
	// ~~~~~~~~~~~~~~~~~~~~

	// shift of the running sum by one whole beat
	localparam gf_elem_t shift_pow = gf_alpha_pow(`BCH_BITS * syn_idx);

	gf_elem_t acc; // running partial syndrome
	gf_elem_t acc_in; // accumulator value the step starts from
	gf_elem_t acc_shift; // acc_in times alpha^(bits*j)
	gf_elem_t acc_next; // value after adding the new beat
	gf_elem_t [`BCH_BITS-1:0] terms; // data[i] * alpha^(i*j)

	// a start beat throws away whatever was left from an old or broken frame
	assign acc_in = beat.start ? '0 : acc;

	gf_mult u_shift (
		.a(acc_in),
		.b(shift_pow),
		.p(acc_shift)
	);

	// each data bit selects a constant power, no multiplier needed
	for (genvar i = 0; i < `BCH_BITS; i++) begin : g_term
		localparam gf_elem_t coef = gf_alpha_pow(i * syn_idx);
		assign terms[i] = beat.data[i] ? coef : '0;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// sum of the terms
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		acc_next = acc_shift;
		for (int i = 0; i < `BCH_BITS; i++) begin
			acc_next ^= terms[i]; // field addition
		end
	end

	// the accumulator only moves on accepted beats, gaps leave it alone
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (beat.ce) begin
			acc <= acc_next;
		end
	end

	// valid as a finished syndrome in the cycle after a last beat
	assign syn = acc;

endmodule

`default_nettype wire

//--- bch_syndrome_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bch_defines.svh"

// syndrome generator for BCH(15,7), t = 2, three coefficients per beat
module bch_syndrome_top import bch_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic in_valid, // beat strobe
	input logic in_first, // first beat of a frame, sampled with in_valid
	input logic [`BCH_BITS-1:0] in_data, // bit 2 is the highest coefficient
	output syn_vec_t syn_out,
	output logic syn_valid, // one cycle per finished frame
	output logic err_detected
);

	logic frame_last;
	gf_elem_t s1;
	gf_elem_t s3;

	bch_beat_if u_beat ();

	// ~~~~~~~~~~~~~~~~~~~~
	// framing
	// ~~~~~~~~~~~~~~~~~~~~

	bch_frame_ctrl u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_data(in_data),
		.beat(u_beat.ctrl),
		.last(frame_last)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// odd syndromes
	// ~~~~~~~~~~~~~~~~~~~~

	bch_syn_unit #(.syn_idx(1)) u_syn1 (
		.clk(clk),
		.rst_n(rst_n),
		.beat(u_beat.unit),
		.syn(s1)
	);

	bch_syn_unit #(.syn_idx(3)) u_syn3 (
		.clk(clk),
		.rst_n(rst_n),
		.beat(u_beat.unit),
		.syn(s3)
	);

	bch_syn_check u_check (
		.clk(clk),
		.rst_n(rst_n),
		.last(frame_last),
		.s1(s1),
		.s3(s3),
		.syn_out(syn_out),
		.syn_valid(syn_valid),
		.err_detected(err_detected)
	);

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
bch_pkg.sv
bch_beat_if.sv
gf_mult.sv
bch_syn_unit.sv
bch_frame_ctrl.sv
bch_syn_check.sv
bch_syndrome_top.sv
tb_bch_syndrome.sv

//--- gf_mult.sv
`timescale 1ns/1ps
`default_nettype none

`include "bch_defines.svh"

// standard basis multiplier over GF(2^4), purely combinational
module gf_mult import bch_pkg::*; (
	input gf_elem_t a,
	input gf_elem_t b,
	output gf_elem_t p
);

	// carry-less product has degree up to 2*(m-1)
	logic [2*`BCH_M-2:0] prod;

	always_comb begin
		prod = '0;

		// ~~~~~~~~~~~~~~~~~~~~
		// partial products
		// ~~~~~~~~~~~~~~~~~~~~
		for (int i = 0; i < `BCH_M; i++) begin
			for (int j = 0; j < `BCH_M; j++) begin
				prod[i+j] ^= a[i] & b[j]; // addition in GF(2) is xor
			end
		end

		// ~~~~~~~~~~~~~~~~~~~~
		// reduction
		// ~~~~~~~~~~~~~~~~~~~~
		// walk down from the top bit so each fold can set lower bits that
		// a later step clears again
		for (int k = 2*`BCH_M-2; k >= `BCH_M; k--) begin
			if (prod[k]) begin
				prod[k -: `BCH_M+1] ^= `BCH_POLY; // x^4 = x + 1
			end
		end
	end

	assign p = prod[`BCH_M-1:0]; // only degree < m is left after reduction

endmodule

`default_nettype wire

//--- tb_bch_syndrome.sv
`timescale 1ns/1ps
`default_nettype none

`include "bch_defines.svh"

module tb_bch_syndrome import bch_pkg::*; ();

	// g(x) = x^8 + x^7 + x^6 + x^4 + 1
	// it is the product of the minimal polynomials of alpha and alpha^3
	localparam logic [`BCH_N-1:0] gen_poly = `BCH_N'('h1d1);

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_first;
	logic [`BCH_BITS-1:0] in_data;
	syn_vec_t syn_out;
	logic syn_valid;
	logic err_detected;

	syn_vec_t exp_q[$]; // model results waiting for their syn_valid
	string cur_test;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int frames_sent = 0;
	int results_seen = 0;

	bch_syndrome_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_first(in_first),
		.in_data(in_data),
		.syn_out(syn_out),
		.syn_valid(syn_valid),
		.err_detected(err_detected)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	// ~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~

	// shift-and-add product, then fold the high bits down from the top
	function automatic gf_elem_t field_mul(input gf_elem_t a, input gf_elem_t b);
		logic [2*`BCH_M-2:0] acc;
		logic [2*`BCH_M-2:0] poly;
		acc = '0;
		poly = (2*`BCH_M-1)'(`BCH_POLY);
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i]) acc ^= (2*`BCH_M-1)'(a) << i;
		end
		for (int k = 2*`BCH_M-2; k >= `BCH_M; k--) begin
			if (acc[k]) acc ^= poly << (k - `BCH_M);
		end
		return acc[`BCH_M-1:0];
	endfunction

	// evaluates r(alpha^j) one coefficient at a time from x^14 down to x^0
	// bit i of the word is the x^i coefficient
	function automatic syn_vec_t model_syn(input logic [`BCH_N-1:0] cw);
		syn_vec_t s;
		gf_elem_t point;
		s = '0;
		for (int j = 1; j <= 2*`BCH_T; j++) begin
			point = gf_alpha_pow(j);
			for (int i = `BCH_N-1; i >= 0; i--) begin
				s[j-1] = field_mul(s[j-1], point) ^ gf_elem_t'(cw[i]);
			end
		end
		return s;
	endfunction

	// non-systematic encoder, message times generator
	function automatic logic [`BCH_N-1:0] encode(input logic [`BCH_K-1:0] msg);
		logic [`BCH_N-1:0] cw;
		cw = '0;
		for (int i = 0; i < `BCH_K; i++) begin
			if (msg[i]) cw ^= gen_poly << i;
		end
		return cw;
	endfunction

	// kind 0 is a clean codeword, 1 and 2 flip that many bits, 3 is any 15-bit word
	function automatic logic [`BCH_N-1:0] make_word(input int kind);
		logic [`BCH_N-1:0] cw;
		int p1;
		int p2;
		cw = encode(`BCH_K'($urandom));
		p1 = $urandom_range(0, `BCH_N-1);
		p2 = (p1 + 1 + $urandom_range(0, `BCH_N-2)) % `BCH_N; // never equal to p1
		case (kind)
			1: cw ^= `BCH_N'(1) << p1;
			2: cw ^= (`BCH_N'(1) << p1) ^ (`BCH_N'(1) << p2);
			3: cw = `BCH_N'($urandom);
			default: ;
		endcase
		return cw;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic check_syn(input syn_vec_t exp, input syn_vec_t act);
		if (act !== exp) begin
			$display("FAIL %s: syn_out expected %h actual %h", cur_test, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL %s: %s expected %b actual %b", cur_test, what, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	// every pulse of syn_valid retires the oldest frame, sampled away from the edge
	always @(negedge clk) begin : monitor
		syn_vec_t exp_v;
		if (syn_valid === 1'b1) begin
			results_seen++;
			if (exp_q.size() == 0) begin
				$display("ERROR %s: syn_valid pulsed with no frame outstanding", cur_test);
				errors++;
				test_errors++;
			end else begin
				exp_v = exp_q.pop_front();
				check_syn(exp_v, syn_out);
				check_flag("err_detected", |exp_v, err_detected); // any non-zero syndrome
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic drive_beat(input logic first, input logic [`BCH_BITS-1:0] data);
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		in_first = first;
		in_data = data;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			in_first = 1'b0;
			in_data = `BCH_BITS'($urandom); // junk data must be ignored
		end
	endtask

	// beat b carries x^(14-3b) down to x^(12-3b), highest bit first
	task automatic send_beats(input logic [`BCH_N-1:0] cw, input int n, input bit gaps);
		for (int b = 0; b < n; b++) begin
			if (gaps) idle_cycles($urandom_range(0, 2));
			drive_beat(b == 0, cw[`BCH_N-1-`BCH_BITS*b -: `BCH_BITS]);
		end
	endtask

	task automatic send_frame(input logic [`BCH_N-1:0] cw, input bit gaps);
		syn_vec_t s;
		send_beats(cw, `BCH_BEATS, gaps);
		s = model_syn(cw);
		exp_q.push_back(s);
		frames_sent++;
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("ERROR %s: timed out waiting for syn_valid, %0d results missing",
				cur_test, exp_q.size());
			errors++;
			test_errors++;
			exp_q.delete();
		end
		idle_cycles(2); // lets the monitor settle before the next test
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %s finished with %0d errors", cur_test, test_errors);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~

	initial begin
		int base_frames;
		int base_results;
		int part;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_data = '0;
		void'($urandom(32'he592));

		start_test("reset");
		for (int c = 0; c < 16; c++) begin
			@(posedge clk);
			#1;
			check_flag("syn_valid", 1'b0, syn_valid);
			check_flag("err_detected", 1'b0, err_detected);
			check_syn('0, syn_out);
		end
		rst_n = 1'b1;
		for (int c = 0; c < 8; c++) begin
			idle_cycles(1);
			check_flag("syn_valid", 1'b0, syn_valid);
			check_flag("err_detected", 1'b0, err_detected);
			check_syn('0, syn_out);
		end
		end_test();

		start_test("valid_codewords");
		for (int n = 0; n < 40; n++) begin
			send_frame(make_word(0), 1'b0);
			idle_cycles($urandom_range(0, 2));
		end
		wait_results();
		end_test();

		start_test("error_words");
		for (int n = 0; n < 40; n++) begin
			send_frame(make_word($urandom_range(1, 3)), 1'b0);
			idle_cycles($urandom_range(0, 2));
		end
		wait_results();
		end_test();

		start_test("streaming");
		base_frames = frames_sent;
		base_results = results_seen;
		for (int n = 0; n < 30; n++) begin
			send_frame(make_word($urandom_range(0, 3)), n >= 15); // second half has gaps
		end
		idle_cycles(1);
		wait_results();
		if (results_seen - base_results != frames_sent - base_frames) begin
			$display("FAIL %s: result count expected %0d actual %0d", cur_test,
				frames_sent - base_frames, results_seen - base_results);
			errors++;
			test_errors++;
		end
		end_test();

		start_test("restart");
		for (int n = 0; n < 12; n++) begin
			part = $urandom_range(1, `BCH_BEATS-1);
			send_beats(make_word(3), part, 1'b0); // abandoned, never reaches the model
			send_frame(make_word($urandom_range(0, 3)), 1'b0);
			idle_cycles($urandom_range(0, 2));
		end
		wait_results();
		end_test();

		start_test("stray_beats");
		base_results = results_seen;
		for (int n = 0; n < 3; n++) begin
			repeat ($urandom_range(`BCH_BEATS, `BCH_BEATS+2)) begin
				drive_beat(1'b0, `BCH_BITS'($urandom));
			end
			idle_cycles(3);
		end
		idle_cycles(10);
		if (results_seen != base_results) begin
			$display("ERROR %s: beats without in_first while idle produced a result", cur_test);
			errors++;
			test_errors++;
		end
		send_frame(make_word(1), 1'b0); // the controller must still frame normally
		idle_cycles(1);
		wait_results();
		end_test();

		$display("%0d tests, %0d frames sent, %0d results seen, %0d errors",
			tests_run, frames_sent, results_seen, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
